// ==== loader_pkg.sv ====
// shared types and constants for the sound RAM loader
// covers bus word and address widths, request records, the loader FSM
// states and the two fixed register blocks sent on F1 and F2
// every design file refers to these through loader_pkg:: scoped names
`default_nettype none

package loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////
	localparam int word_w     = 16;
	localparam int ram_addr_w = 20;
	localparam int addr_hi_w  = 4;
	localparam int key_code_w = 9;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [ram_addr_w-1:0] ram_addr_t;
	typedef logic [addr_hi_w-1:0]  addr_hi_t;
	typedef logic [key_code_w-1:0] key_code_t;

	// keyboard event, toggle flips once per new event
	typedef struct packed {
		logic      toggle;
		logic      pressed;
		key_code_t code;
	} key_event_t;

	// one host bus write as the bus master consumes it
	typedef struct packed {
		addr_hi_t addr_hi;
		word_t    addr_lo;
		word_t    data;
		logic     last;
	} write_req_t;

	// multiplexed host bus outputs, controls all active low
	typedef struct packed {
		word_t data;
		logic  ad_n;
		logic  dten_n;
		logic  cs_n;
		logic  we_n;
	} snd_bus_t;

	typedef enum logic [2:0] {
		idle,
		rst_hold,
		dl_wait,
		dl_write,
		cmd_write,
		dl_end
	} loader_state_t;

	//////////////////////////////////////////////////////////////////////
	// preset register blocks
	//////////////////////////////////////////////////////////////////////
	localparam int preset_len      = 8;
	localparam int rst_hold_cycles = 4;

	// scan codes of the trigger keys
	localparam key_code_t key_f1 = 9'h005;
	localparam key_code_t key_f2 = 9'h006;

	// words[0] is written first, at base
	typedef struct packed {
		word_t                    base;
		word_t [0:preset_len-1]   words;
	} preset_t;

	localparam preset_t preset_0 = '{
		base:  16'h0700,
		words: {16'h8500, 16'h0000, 16'h5000, 16'h8000,
			16'h7942, 16'h0700, 16'h0000, 16'h0000}
	};

	localparam preset_t preset_1 = '{
		base:  16'h0760,
		words: {16'h0100, 16'h0300, 16'h030F, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};

endpackage

`default_nettype wire

// ==== download_port.sv ====
// one-entry buffer between the download stream and the bus master
// takes a word over valid/ready, splits its byte address into the two
// bus address phases, swaps the data bytes and flags the last RAM word
// RAM_ADDR_W sets how many byte-address bits the sound RAM has
`default_nettype none

module download_port #(
	parameter int RAM_ADDR_W = 19
) (
	input  wire                    clk_sys,
	input  wire                    rst,

	// download stream
	input  wire                    dl_valid,
	input  loader_pkg::ram_addr_t  dl_addr,
	input  loader_pkg::word_t      dl_data,
	output logic                   dl_ready,

	// towards the bus master
	output loader_pkg::write_req_t req,
	output logic                   req_valid,
	input  wire                    req_ready
);

	logic full;
	logic full_nxt;
	logic take_in;
	logic give_out;
	loader_pkg::write_req_t req_q;

	assign take_in  = dl_valid && dl_ready;
	assign give_out = req_valid && req_ready;

	// buffer state after this clock
	always_comb begin
		full_nxt = full;
		if (take_in) begin
			full_nxt = 1'b1;
		end else if (give_out) begin
			full_nxt = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////
	// ready is registered so it stays low through reset
	// and comes up one cycle later
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			full     <= 1'b0;
			dl_ready <= 1'b0;
		end else begin
			full     <= full_nxt;
			dl_ready <= !full_nxt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (take_in) begin
			// phase 1 carries only bits 18..16
			req_q.addr_hi <= {1'b0, dl_addr[18:16]};
			// word address, byte lane bit dropped
			req_q.addr_lo <= {dl_addr[15:1], 1'b0};
			// chip expects the bytes the other way round
			req_q.data    <= {dl_data[7:0], dl_data[15:8]};
			// top word of RAM ends the download
			req_q.last    <= &dl_addr[RAM_ADDR_W-1:1];
		end
	end

	assign req       = req_q;
	assign req_valid = full;

endmodule

`default_nettype wire

// ==== preset_sequencer.sv ====
// plays one of two fixed register blocks on an F1 or F2 key event
// each block becomes preset_len write requests to consecutive words
// from the preset base, handed to the bus master over valid/ready
// one block at most is pending, keys are dropped while it plays
`default_nettype none

module preset_sequencer (
	input  wire                    clk_sys,
	input  wire                    rst,

	input  loader_pkg::key_event_t key,

	output loader_pkg::write_req_t req,
	output logic                   req_valid,
	input  wire                    req_ready
);

	localparam int idx_w = $clog2(loader_pkg::preset_len);
	localparam logic [idx_w-1:0] idx_last = idx_w'(loader_pkg::preset_len - 1);

	logic             toggle_q;
	logic             new_event;
	logic             hit_f1;
	logic             hit_f2;
	logic             busy;
	logic             sel_1;
	logic [idx_w-1:0] idx;
	logic             is_last;
	loader_pkg::preset_t cur_preset;

	//////////////////////////////////////////////////////////////////////
	// key event detect
	//////////////////////////////////////////////////////////////////////
	// toggle edge with the key held down counts as a new press
	assign new_event = (key.toggle != toggle_q) && key.pressed;
	assign hit_f1    = key.code == loader_pkg::key_f1;
	assign hit_f2    = key.code == loader_pkg::key_f2;

	//////////////////////////////////////////////////////////////////////
	// block playback
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			toggle_q <= 1'b0;
			busy     <= 1'b0;
			sel_1    <= 1'b0;
			idx      <= '0;
		end else begin
			toggle_q <= key.toggle;
			if (!busy) begin
				// only the two function keys start a block
				if (new_event && (hit_f1 || hit_f2)) begin
					busy  <= 1'b1;
					sel_1 <= hit_f2;
					idx   <= '0;
				end
			end else if (req_ready) begin
				// word accepted by the master
				if (is_last) begin
					busy <= 1'b0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// request build
	//////////////////////////////////////////////////////////////////////
	// all of it comes from registers, stable while valid waits
	assign cur_preset = sel_1 ? loader_pkg::preset_1 : loader_pkg::preset_0;
	assign is_last    = idx == idx_last;

	always_comb begin
		req.addr_hi = '0;
		// word index to byte offset
		req.addr_lo = cur_preset.base + (loader_pkg::word_t'(idx) << 1);
		req.data    = cur_preset.words[idx];
		req.last    = is_last;
	end

	assign req_valid = busy;

endmodule

`default_nettype wire

// ==== host_bus_master.sv ====
// loader FSM and host bus master for the sound chip
// accepts write requests from the download port or the preset
// sequencer, downloads first, and runs each one as a four-phase
// multiplexed bus write paced by an internal strobe
// also holds the chip and sound CPU resets around a download
`default_nettype none

module host_bus_master (
	input  wire                    clk_sys,
	input  wire                    rst,

	input  wire                    dl_active,

	input  loader_pkg::write_req_t dl_req,
	input  wire                    dl_req_valid,
	output logic                   dl_req_ready,

	input  loader_pkg::write_req_t cmd_req,
	input  wire                    cmd_req_valid,
	output logic                   cmd_req_ready,

	output loader_pkg::snd_bus_t   snd_bus,
	input  wire                    snd_rdy_n,

	output logic                   snd_rst_n,
	output logic                   cpu_rst_n
);

	localparam int hold_w = $clog2(loader_pkg::rst_hold_cycles);
	localparam logic [hold_w-1:0] hold_last = hold_w'(loader_pkg::rst_hold_cycles - 1);

	loader_pkg::loader_state_t state;
	loader_pkg::write_req_t    cur_req;
	loader_pkg::snd_bus_t      bus_q;

	logic              strobe;
	logic [1:0]        step;
	logic [hold_w-1:0] hold_cnt;
	logic              dl_take;
	logic              cmd_take;
	logic              in_write;
	logic              phase_go;
	logic              write_done;

	//////////////////////////////////////////////////////////////////////
	// handshakes
	//////////////////////////////////////////////////////////////////////
	// stream words only between writes of a download
	assign dl_req_ready  = state == loader_pkg::dl_wait;
	// commands only when no download is running
	assign cmd_req_ready = (state == loader_pkg::idle) && !dl_active;

	assign dl_take  = dl_req_valid && dl_req_ready;
	assign cmd_take = cmd_req_valid && cmd_req_ready;

	assign in_write   = (state == loader_pkg::dl_write) || (state == loader_pkg::cmd_write);
	assign phase_go   = in_write && strobe;
	// phase 4 ends on a strobe with ready seen low
	assign write_done = phase_go && (step == 2'd3) && !snd_rdy_n;

	//////////////////////////////////////////////////////////////////////
	// loader FSM and reset sequencing
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state        <= loader_pkg::idle;
			strobe       <= 1'b0;
			step         <= 2'd0;
			hold_cnt     <= '0;
			snd_rst_n    <= 1'b1;
			cpu_rst_n    <= 1'b1;
			bus_q.ad_n   <= 1'b1;
			bus_q.dten_n <= 1'b1;
			bus_q.cs_n   <= 1'b1;
			bus_q.we_n   <= 1'b1;
		end else begin
			// high every second cycle
			strobe <= !strobe;

			case (state)
				loader_pkg::idle: begin
					hold_cnt <= '0;
					step     <= 2'd0;
					// download wins over a waiting command
					if (dl_active) begin
						snd_rst_n <= 1'b0;
						cpu_rst_n <= 1'b0;
						state     <= loader_pkg::rst_hold;
					end else if (cmd_take) begin
						state <= loader_pkg::cmd_write;
					end
				end

				loader_pkg::rst_hold: begin
					hold_cnt <= hold_cnt + 1'b1;
					if (hold_cnt == hold_last) begin
						// chip out of reset, CPU stays held
						snd_rst_n <= 1'b1;
						state     <= loader_pkg::dl_wait;
					end
				end

				loader_pkg::dl_wait: begin
					if (dl_take) begin
						state <= loader_pkg::dl_write;
					end else if (!dl_active) begin
						// stream closed early
						state <= loader_pkg::dl_end;
					end
				end

				loader_pkg::dl_write, loader_pkg::cmd_write: begin
					if (phase_go) begin
						case (step)
							2'd0: begin
								// address high
								bus_q.cs_n <= 1'b0;
								bus_q.we_n <= 1'b0;
								step       <= 2'd1;
							end
							2'd1: begin
								// address low
								step <= 2'd2;
							end
							2'd2: begin
								// data phase
								bus_q.ad_n   <= 1'b0;
								bus_q.dten_n <= 1'b0;
								step         <= 2'd3;
							end
							default: begin
								// hold until the chip answers
								if (!snd_rdy_n) begin
									bus_q.ad_n   <= 1'b1;
									bus_q.dten_n <= 1'b1;
									bus_q.cs_n   <= 1'b1;
									bus_q.we_n   <= 1'b1;
									step         <= 2'd0;
								end
							end
						endcase
					end
					if (write_done) begin
						if (state == loader_pkg::cmd_write) begin
							state <= loader_pkg::idle;
						end else if (cur_req.last) begin
							state <= loader_pkg::dl_end;
						end else begin
							state <= loader_pkg::dl_wait;
						end
					end
				end

				loader_pkg::dl_end: begin
					// sound CPU runs once the stream is closed
					if (!dl_active) begin
						cpu_rst_n <= 1'b1;
						state     <= loader_pkg::idle;
					end
				end

				default: begin
					state <= loader_pkg::idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// request latch and bus data
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (dl_take) begin
			cur_req <= dl_req;
		end else if (cmd_take) begin
			cur_req <= cmd_req;
		end
	end

	// multiplexed data lines follow the phase
	always_ff @(posedge clk_sys) begin
		if (phase_go) begin
			case (step)
				2'd0:    bus_q.data <= {12'h000, cur_req.addr_hi};
				2'd1:    bus_q.data <= cur_req.addr_lo;
				2'd2:    bus_q.data <= cur_req.data;
				default: begin
					if (!snd_rdy_n) begin
						bus_q.data <= '0;
					end
				end
			endcase
		end
	end

	assign snd_bus = bus_q;

endmodule

`default_nettype wire

// ==== sound_loader_top.sv ====
// sound RAM loader top level
// connects the download port and the preset sequencer to the one
// host bus master and passes the sound RAM size down
`default_nettype none

module sound_loader_top #(
	parameter int RAM_ADDR_W = 19
) (
	input  wire                    clk_sys,
	input  wire                    rst,

	// download stream
	input  wire                    dl_active,
	input  wire                    dl_valid,
	input  loader_pkg::ram_addr_t  dl_addr,
	input  loader_pkg::word_t      dl_data,
	output logic                   dl_ready,

	// keyboard
	input  loader_pkg::key_event_t key,

	// sound chip host bus and resets
	output loader_pkg::snd_bus_t   snd_bus,
	input  wire                    snd_rdy_n,
	output logic                   snd_rst_n,
	output logic                   cpu_rst_n
);

	loader_pkg::write_req_t dl_req;
	logic                   dl_req_valid;
	logic                   dl_req_ready;
	loader_pkg::write_req_t cmd_req;
	logic                   cmd_req_valid;
	logic                   cmd_req_ready;

	// stream words into bus requests
	download_port #(
		.RAM_ADDR_W(RAM_ADDR_W)
	) u_download (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl_valid  (dl_valid),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_ready  (dl_ready),
		.req       (dl_req),
		.req_valid (dl_req_valid),
		.req_ready (dl_req_ready)
	);

	// F1/F2 register blocks
	preset_sequencer u_preset (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.key       (key),
		.req       (cmd_req),
		.req_valid (cmd_req_valid),
		.req_ready (cmd_req_ready)
	);

	host_bus_master u_master (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.dl_active     (dl_active),
		.dl_req        (dl_req),
		.dl_req_valid  (dl_req_valid),
		.dl_req_ready  (dl_req_ready),
		.cmd_req       (cmd_req),
		.cmd_req_valid (cmd_req_valid),
		.cmd_req_ready (cmd_req_ready),
		.snd_bus       (snd_bus),
		.snd_rdy_n     (snd_rdy_n),
		.snd_rst_n     (snd_rst_n),
		.cpu_rst_n     (cpu_rst_n)
	);

endmodule

`default_nettype wire

// ==== tb_bus_target.sv ====
// behavioral model of the sound chip host bus for the testbench
// watches the four-phase write, rebuilds each write as a record and
// pulses rec_valid once per write in its data phase
// answers with snd_rdy_n low after a random delay of 0 to 5 cycles
`default_nettype none

module tb_bus_target (
	input  wire                       clk_sys,
	input  wire                       rst,
	input  wire loader_pkg::snd_bus_t snd_bus,
	output logic                      snd_rdy_n,
	output logic                      rec_valid,
	output loader_pkg::write_req_t    rec
);

	integer seed = 19437;

	logic              cs_q;
	logic              ad_q;
	loader_pkg::word_t data_q;
	logic              waiting;
	int                delay;

	always @(posedge clk_sys) begin
		if (rst) begin
			snd_rdy_n <= 1'b1;
			rec_valid <= 1'b0;
			rec       <= '0;
			cs_q      <= 1'b1;
			ad_q      <= 1'b1;
			data_q    <= '0;
			waiting   <= 1'b0;
			delay     <= 0;
		end else begin
			rec_valid <= 1'b0;
			// previous bus sample, for edge detection
			cs_q   <= snd_bus.cs_n;
			ad_q   <= snd_bus.ad_n;
			data_q <= snd_bus.data;

			// chip select falls with write enable in the address high phase
			if (cs_q && !snd_bus.cs_n && !snd_bus.we_n) begin
				rec.addr_hi <= snd_bus.data[3:0];
			end

			// data phase with data enable, the sample before held the address low
			if (ad_q && !snd_bus.ad_n && !snd_bus.dten_n) begin
				rec.addr_lo <= data_q;
				rec.data    <= snd_bus.data;
				rec.last    <= 1'b0;
				rec_valid   <= 1'b1;
				waiting     <= 1'b1;
				delay       <= {$random(seed)} % 6;
			end else if (waiting) begin
				if (delay == 0) begin
					snd_rdy_n <= 1'b0;
					waiting   <= 1'b0;
				end else begin
					delay <= delay - 1;
				end
			end

			// ready goes away once the master closes the cycle
			if (!snd_rdy_n && snd_bus.cs_n) begin
				snd_rdy_n <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_props.sv ====
// concurrent checks on the host bus master outputs
// bound into host_bus_master from the testbench top
`default_nettype none

module tb_props (
	input wire                       clk_sys,
	input wire                       rst,
	input wire loader_pkg::snd_bus_t snd_bus,
	input wire                       snd_rdy_n
);

	// data phase only inside chip select
	ad_in_cs: assert property (@(posedge clk_sys) disable iff (rst)
		!snd_bus.ad_n |-> !snd_bus.cs_n)
		else $error("ad_n low while cs_n is high");

	// write cycle closes only after the chip answered
	cs_end_after_ready: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(snd_bus.cs_n) |-> !$past(snd_rdy_n))
		else $error("cs_n rose without snd_rdy_n seen low");

	// all controls inactive when reset ends
	idle_after_reset: assert property (@(posedge clk_sys)
		$fell(rst) |-> (snd_bus.cs_n && snd_bus.we_n && snd_bus.ad_n && snd_bus.dten_n))
		else $error("bus controls not high after reset");

endmodule

`default_nettype wire

// ==== tb_sound_loader.sv ====
// testbench top for the sound RAM loader
// directed tests for download, reset sequencing, F1/F2 presets and
// bus back-pressure, against a bus model with random ready delays
// errors are counted and reported in one summary line at the end
`default_nettype none

module tb_sound_loader;

	localparam int clk_period   = 20;
	localparam int reset_cycles = 5;
	// about 45 bus writes of up to 20 cycles plus reset holds and quiet gaps
	localparam int max_cycles   = 4000;
	localparam int quiet_cycles = 60;

	// preset blocks as the chip expects them
	localparam loader_pkg::word_t ref_base [2] = '{16'h0700, 16'h0760};
	localparam loader_pkg::word_t ref_words [2][8] = '{
		'{16'h8500, 16'h0000, 16'h5000, 16'h8000, 16'h7942, 16'h0700, 16'h0000, 16'h0000},
		'{16'h0100, 16'h0300, 16'h030F, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};

	logic                   clk_sys;
	logic                   rst;
	logic                   dl_active;
	logic                   dl_valid;
	loader_pkg::ram_addr_t  dl_addr;
	loader_pkg::word_t      dl_data;
	logic                   dl_ready;
	loader_pkg::key_event_t key;
	loader_pkg::snd_bus_t   snd_bus;
	logic                   snd_rdy_n;
	logic                   snd_rst_n;
	logic                   cpu_rst_n;
	logic                   rec_valid;
	loader_pkg::write_req_t rec;

	loader_pkg::write_req_t got_q[$];
	loader_pkg::ram_addr_t  addr_list[$];
	loader_pkg::word_t      data_list[$];
	int                     rd_idx;
	int                     errors;
	int                     checks;
	int                     cycle_cnt = 0;
	integer                 seed;

	sound_loader_top #(
		.RAM_ADDR_W(19)
	) u_dut (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl_active (dl_active),
		.dl_valid  (dl_valid),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_ready  (dl_ready),
		.key       (key),
		.snd_bus   (snd_bus),
		.snd_rdy_n (snd_rdy_n),
		.snd_rst_n (snd_rst_n),
		.cpu_rst_n (cpu_rst_n)
	);

	tb_bus_target u_target (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.snd_bus   (snd_bus),
		.snd_rdy_n (snd_rdy_n),
		.rec_valid (rec_valid),
		.rec       (rec)
	);

	bind host_bus_master tb_props u_props (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.snd_bus   (snd_bus),
		.snd_rdy_n (snd_rdy_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// every finished bus write lands here
	always @(posedge clk_sys) begin
		if (rec_valid) begin
			got_q.push_back(rec);
		end
	end

	// run limit
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("timeout, run did not finish within %0d cycles", max_cycles);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_write(input string name, input loader_pkg::write_req_t exp,
			input loader_pkg::write_req_t act);
		checks++;
		if (act.addr_hi !== exp.addr_hi || act.addr_lo !== exp.addr_lo
				|| act.data !== exp.data) begin
			errors++;
			$display("** Error %s: expected %h/%h/%h, actual %h/%h/%h", name,
				exp.addr_hi, exp.addr_lo, exp.data, act.addr_hi, act.addr_lo, act.data);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// expected writes and helpers
	//////////////////////////////////////////////////////////////////////
	// address split and byte swap of a download word
	function automatic loader_pkg::write_req_t expected_download_write(
			input loader_pkg::ram_addr_t a, input loader_pkg::word_t d);
		loader_pkg::write_req_t r;
		r.addr_hi = 4'((a >> 16) & 20'h7);
		r.addr_lo = 16'(a) & 16'hFFFE;
		r.data    = (d << 8) | (d >> 8);
		r.last    = 1'b0;
		return r;
	endfunction

	function automatic loader_pkg::write_req_t expected_preset_write(input int p, input int i);
		loader_pkg::write_req_t r;
		r.addr_hi = '0;
		r.addr_lo = ref_base[p] + 16'(2 * i);
		r.data    = ref_words[p][i];
		r.last    = 1'b0;
		return r;
	endfunction

	function automatic int pending_writes();
		return got_q.size() - rd_idx;
	endfunction

	task automatic wait_writes(input int n);
		while (pending_writes() < n) @(negedge clk_sys);
	endtask

	task automatic expect_write(input string name, input loader_pkg::write_req_t exp);
		loader_pkg::write_req_t act;
		act = got_q[rd_idx];
		rd_idx++;
		check_write(name, exp, act);
	endtask

	// let a write that is still in phase 4 finish
	task automatic wait_bus_idle();
		while (!snd_bus.cs_n) @(negedge clk_sys);
	endtask

	task automatic send_key(input loader_pkg::key_code_t code);
		loader_pkg::key_event_t ev;
		@(posedge clk_sys);
		ev         = key;
		ev.toggle  = !key.toggle;
		ev.pressed = 1'b1;
		ev.code    = code;
		key <= ev;
	endtask

	task automatic queue_word(input loader_pkg::ram_addr_t a);
		addr_list.push_back(a);
		data_list.push_back(16'($random(seed)));
	endtask

	// call right after a rising edge, returns at the edge of the transfer
	task automatic stream_word(input loader_pkg::ram_addr_t a, input loader_pkg::word_t d);
		dl_valid <= 1'b1;
		dl_addr  <= a;
		dl_data  <= d;
		@(negedge clk_sys);
		while (!dl_ready) @(negedge clk_sys);
		@(posedge clk_sys);
	endtask

	// whole download of the queued words with reset checks
	task automatic run_download(input string name, input bit key_mid);
		int hold;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		// first word waits in the port while the chip is held
		stream_word(addr_list[0], data_list[0]);
		dl_valid <= 1'b0;
		@(negedge clk_sys);
		check_level({name, " snd_rst_n at start"}, 1'b0, snd_rst_n);
		check_level({name, " cpu_rst_n at start"}, 1'b0, cpu_rst_n);
		hold = 0;
		while (!snd_rst_n) begin
			// no bus cycle while the chip is in reset
			check_level({name, " cs_n during chip reset"}, 1'b1, snd_bus.cs_n);
			hold++;
			@(negedge clk_sys);
		end
		check_count({name, " snd_rst_n hold cycles"}, 4, hold);
		check_level({name, " cs_n at chip reset release"}, 1'b1, snd_bus.cs_n);
		if (key_mid) begin
			send_key(loader_pkg::key_f1);
		end
		@(posedge clk_sys);
		for (int i = 1; i < addr_list.size(); i++) begin
			stream_word(addr_list[i], data_list[i]);
		end
		dl_valid <= 1'b0;
		wait_writes(addr_list.size());
		foreach (addr_list[i]) begin
			expect_write(name, expected_download_write(addr_list[i], data_list[i]));
		end
		wait_bus_idle();
		// stream still open, CPU held and commands blocked
		repeat (quiet_cycles) @(negedge clk_sys);
		check_level({name, " cpu_rst_n before stream close"}, 1'b0, cpu_rst_n);
		check_count({name, " command writes during download"}, 0, pending_writes());
		@(posedge clk_sys);
		dl_active <= 1'b0;
		while (!cpu_rst_n) @(negedge clk_sys);
		check_level({name, " snd_rst_n after download"}, 1'b1, snd_rst_n);
		addr_list.delete();
		data_list.delete();
	endtask

	// eight writes of one preset block in table order
	task automatic check_preset_block(input string name, input int p);
		wait_writes(8);
		for (int i = 0; i < 8; i++) begin
			expect_write(name, expected_preset_write(p, i));
		end
		wait_bus_idle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_after_reset();
		@(negedge clk_sys);
		check_level("reset cs_n", 1'b1, snd_bus.cs_n);
		check_level("reset we_n", 1'b1, snd_bus.we_n);
		check_level("reset ad_n", 1'b1, snd_bus.ad_n);
		check_level("reset dten_n", 1'b1, snd_bus.dten_n);
		check_level("reset snd_rst_n", 1'b1, snd_rst_n);
		check_level("reset cpu_rst_n", 1'b1, cpu_rst_n);
		check_level("reset dl_ready", 1'b0, dl_ready);
	endtask

	task automatic test_download();
		queue_word(20'h00000);
		queue_word(20'h12344);
		// odd byte address, bit 0 dropped
		queue_word(20'h0ABCF);
		queue_word(20'h3FFF0);
		// bit 19 lies outside the RAM
		queue_word(20'h91234);
		queue_word(20'h5A5A4);
		queue_word(20'h7FFFC);
		queue_word(20'h7FFFE);
		run_download("download", 1'b0);
	endtask

	task automatic test_preset(input string name, input loader_pkg::key_code_t code,
			input int p);
		send_key(code);
		check_preset_block(name, p);
	endtask

	task automatic test_other_key();
		send_key(9'h01C);
		repeat (quiet_cycles) @(negedge clk_sys);
		check_count("non-F key writes", 0, pending_writes());
	endtask

	task automatic test_key_during_download();
		queue_word(20'h01230);
		queue_word(20'h7FFFE);
		run_download("key during download", 1'b1);
		// held F1 block plays once the stream is closed, no new key
		check_preset_block("F1 after download", 0);
	endtask

	task automatic test_backpressure();
		loader_pkg::ram_addr_t a;
		for (int i = 0; i < 7; i++) begin
			a = 20'($random(seed));
			// bit 1 clear keeps it off the top RAM word
			a[1] = 1'b0;
			queue_word(a);
		end
		queue_word(20'h7FFFE);
		run_download("back-pressure", 1'b0);
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		rd_idx    = 0;
		seed      = 19437;
		rst       = 1'b1;
		dl_active = 1'b0;
		dl_valid  = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		key       = '0;
		repeat (reset_cycles) @(posedge clk_sys);
		rst <= 1'b0;

		test_after_reset();
		test_download();
		test_preset("F1 preset", loader_pkg::key_f1, 0);
		test_preset("F2 preset", loader_pkg::key_f2, 1);
		test_other_key();
		test_key_during_download();
		test_backpressure();

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
loader_pkg.sv
download_port.sv
preset_sequencer.sv
host_bus_master.sv
sound_loader_top.sv
tb_bus_target.sv
tb_props.sv
tb_sound_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
# the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sound_loader -f build.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
